//--- flist.f
hw/idec_pkg.sv
hw/decode_bus_if.sv
hw/inst_byte_decode.sv
hw/branch_ctrl.sv
hw/exec_stage_reg.sv
hw/inst_decoder.sv
testbench/decode_checker.sv
testbench/tb_inst_decoder.sv

//--- Makefile
# Verilator build and run of the decode stage testbench

sim:
	verilator --binary --timing -f flist.f --top-module tb_inst_decoder -Mdir obj_dir
	./obj_dir/Vtb_inst_decoder | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- testbench/decode_cases.txt
// id en inst sr cr_update_en cr_update, then outputs one cycle later: exec_ctrl addr imm
// imm_vld ifetch_en exec_en cr src0_rd src1_rd src0 src1 dst; id fff closes the list
// alu register and immediate forms
001 1 29 00 0 00 1 000 00 0 1 1 1c 1 1 2 1 1
001 1 36 00 0 00 1 000 00 0 1 1 1c 1 0 1 2 2
001 1 5a 00 0 00 0 000 5a 1 1 0 1c 0 0 1 2 2
001 1 4c 00 0 00 2 000 5a 0 1 1 1c 1 1 3 0 0
001 1 b3 00 0 00 5 000 5a 0 1 1 1c 1 0 0 3 3
001 0 c3 00 0 00 5 000 5a 0 1 0 1c 0 0 0 3 3
001 1 c3 00 0 00 0 000 c3 1 1 0 1c 0 0 0 3 3
001 1 00 00 0 00 0 000 c3 0 1 1 1c 0 0 0 0 0
// ld, st and unconditional jmp
002 1 d5 00 0 00 6 000 c3 0 1 1 1c 0 0 1 1 2
002 1 3c 00 0 00 0 53c c3 0 1 0 1c 0 0 1 1 2
002 1 eb 00 0 00 7 53c c3 0 1 1 1c 1 0 1 3 3
002 1 a7 00 0 00 0 3a7 c3 0 1 0 1c 0 0 1 3 3
002 1 16 00 0 00 8 3a7 c3 0 1 1 1c 0 0 1 2 2
002 1 f0 00 0 00 0 6f0 c3 0 1 0 1c 0 0 1 2 2
// conditional jmp/call on z, overflow and nz
003 1 03 00 0 00 0 6f0 c3 0 1 1 1d 0 0 0 3 3
003 1 12 08 0 00 8 6f0 c3 0 1 1 1d 0 0 0 2 2
003 1 44 08 0 00 0 244 c3 0 1 0 1d 0 0 0 2 2
003 1 12 00 0 00 0 244 c3 0 1 1 1d 0 0 0 2 2
003 1 55 00 0 00 0 255 c3 0 1 0 1d 0 0 0 2 2
003 1 04 00 0 00 0 255 c3 0 1 1 1f 0 0 1 0 0
003 1 1a 01 0 00 9 255 c3 0 1 1 1f 0 0 2 2 2
003 1 81 01 0 00 0 281 c3 0 1 0 1f 0 0 2 2 2
003 1 1a 0c 0 00 0 281 c3 0 1 1 1f 0 0 2 2 2
003 1 82 0c 0 00 0 282 c3 0 1 0 1f 0 0 2 2 2
003 1 05 00 0 00 0 282 c3 0 1 1 1c 0 0 1 1 1
003 1 04 00 0 00 0 282 c3 0 1 1 1e 0 0 1 0 0
003 1 12 04 0 00 8 282 c3 0 1 1 1e 0 0 0 2 2
003 1 33 04 0 00 0 233 c3 0 1 0 1e 0 0 0 2 2
003 1 12 08 0 00 0 233 c3 0 1 1 1e 0 0 0 2 2
003 1 34 08 0 00 0 234 c3 0 1 0 1e 0 0 0 2 2
// cr instructions and external writes
004 1 06 00 0 00 0 234 c3 0 1 1 3e 0 0 1 2 2
004 0 00 00 1 a5 0 234 c3 0 1 0 a5 0 0 1 2 2
004 1 07 00 1 60 0 234 c3 0 1 1 40 0 0 1 3 3
004 1 03 00 1 1c 0 234 c3 0 1 1 1d 0 0 0 3 3
004 1 05 00 0 00 0 234 c3 0 1 1 1c 0 0 1 1 1
// ret window
005 1 01 00 0 00 a 234 c3 0 0 1 1c 0 0 0 1 1
005 1 29 00 0 00 0 234 c3 0 0 0 1c 0 0 0 1 1
005 1 29 00 0 00 0 234 c3 0 1 0 1c 0 0 0 1 1
005 1 29 00 0 00 0 234 c3 0 1 0 1c 0 0 0 1 1
005 1 29 00 0 00 0 234 c3 0 1 0 1c 0 0 0 1 1
005 1 29 00 0 00 1 234 c3 0 1 1 1c 1 1 2 1 1
// sticky halt
006 1 02 00 0 00 0 234 c3 0 0 0 1c 0 0 0 2 2
006 1 29 00 0 00 0 234 c3 0 0 0 1c 0 0 0 2 2
006 1 36 00 0 00 0 234 c3 0 0 0 1c 0 0 0 2 2
006 1 5a 00 0 00 0 234 c3 0 0 0 1c 0 0 0 2 2
006 0 00 00 0 00 0 234 c3 0 0 0 1c 0 0 0 2 2
fff 0 00 00 0 00 0 000 00 0 0 0 00 0 0 0 0 0

//--- testbench/tb_inst_decoder.sv
//********************************************************************
// tb_inst_decoder
// replays the cases file one line per cycle into the decode stage
//********************************************************************
module tb_inst_decoder
    import idec_pkg::*;
();
    localparam int          NCOL      = 18;       // columns per cases line
    localparam int          MAX_LINES = 128;
    localparam logic [11:0] END_ID    = 12'hfff;  // id of the closing line

    logic        clk;
    logic        reset_;
    logic        idecode_en;
    inst_t       inst_i;
    ctrl_reg_t   sr;
    ctrl_reg_t   cr_update;
    logic        cr_update_en;
    exec_op_t    exec_ctrl;
    reg_ptr_t    exec_src0_reg;
    logic        exec_src0_reg_rd_en;
    reg_ptr_t    exec_src1_reg;
    logic        exec_src1_reg_rd_en;
    reg_ptr_t    exec_dst_reg;
    addr_t       exec_addr;
    imm_t        exec_imm_val;
    logic        exec_imm_val_vld;
    logic        decode2ifetch_en;
    logic        decode2exec_en;
    ctrl_reg_t   cr;

    logic [11:0] cases [0:NCOL*MAX_LINES-1];
    logic [11:0] exp_row [0:11];
    logic [11:0] test_id;
    logic        case_vld;
    logic        all_sent;
    logic        report_done;
    logic        file_ok;
    int          pass_cnt;
    int          fail_cnt;
    int          n_lines;
    int          cyc;

    inst_decoder inst_decoder_i (.*);

    decode_checker u_checker (
        .clk (clk), .case_vld (case_vld), .all_sent (all_sent), .test_id (test_id),
        .exp_row (exp_row), .exec_ctrl (exec_ctrl), .exec_addr (exec_addr),
        .exec_imm_val (exec_imm_val), .exec_imm_val_vld (exec_imm_val_vld),
        .decode2ifetch_en (decode2ifetch_en), .decode2exec_en (decode2exec_en),
        .cr (cr), .exec_src0_reg_rd_en (exec_src0_reg_rd_en),
        .exec_src1_reg_rd_en (exec_src1_reg_rd_en), .exec_src0_reg (exec_src0_reg),
        .exec_src1_reg (exec_src1_reg), .exec_dst_reg (exec_dst_reg),
        .pass_cnt (pass_cnt), .fail_cnt (fail_cnt), .report_done (report_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic drive_idle();
        idecode_en   = 1'b0;
        inst_i       = '0;
        sr           = '0;
        cr_update_en = 1'b0;
        cr_update    = '0;
        case_vld     = 1'b0;
    endtask

    task automatic drive_line(input int line);
        int base;
        int k;
        base         = line * NCOL;
        test_id      = cases[base];
        idecode_en   = cases[base + 1][0];
        inst_i       = cases[base + 2][7:0];
        sr           = cases[base + 3][7:0];
        cr_update_en = cases[base + 4][0];
        cr_update    = cases[base + 5][7:0];
        for (k = 0; k < 12; k++) begin
            exp_row[k] = cases[base + 6 + k];   // outputs one cycle later
        end
        case_vld = 1'b1;
    endtask

    function automatic int count_lines();
        int n;
        n = 0;
        while (n < MAX_LINES && cases[n * NCOL] != END_ID) begin
            n++;
        end
        return n;
    endfunction

    initial begin
        drive_idle();
        reset_   = 1'b0;
        all_sent = 1'b0;
        test_id  = '0;
        for (int k = 0; k < 12; k++) begin
            exp_row[k] = '0;
        end
        $readmemh("testbench/decode_cases.txt", cases);
        n_lines = count_lines();
        file_ok = (n_lines > 0) && (n_lines < MAX_LINES);
        repeat (4) @(posedge clk);
        #1;
        reset_ = 1'b1;
        cyc    = 0;
        while (file_ok && !report_done && cyc < n_lines + 20) begin
            @(posedge clk);
            #1;
            if (cyc < n_lines) begin
                drive_line(cyc);
            end else if (cyc == n_lines) begin
                drive_idle();
            end else begin
                all_sent = 1'b1;    // checker closes the last test
            end
            cyc++;
        end
        if (!file_ok) begin
            $display("cases file is empty or has no closing line");
            $display("Simulation FAILED");
        end else if (!report_done) begin
            $display("timeout after %0d cycles, checker never finished", cyc);
            $display("Simulation FAILED");
        end else begin
            $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
        end
        $finish;
    end

endmodule

//--- testbench/decode_checker.sv
//********************************************************************
// decode_checker
// holds the expected row of each sampled line for one cycle and
// compares it with the DUT outputs, keeps per-test results
//********************************************************************
module decode_checker
    import idec_pkg::*;
(
    input  logic        clk,
    input  logic        case_vld,
    input  logic        all_sent,
    input  logic [11:0] test_id,
    input  logic [11:0] exp_row [0:11],
    input  exec_op_t    exec_ctrl,
    input  addr_t       exec_addr,
    input  imm_t        exec_imm_val,
    input  logic        exec_imm_val_vld,
    input  logic        decode2ifetch_en,
    input  logic        decode2exec_en,
    input  ctrl_reg_t   cr,
    input  logic        exec_src0_reg_rd_en,
    input  logic        exec_src1_reg_rd_en,
    input  reg_ptr_t    exec_src0_reg,
    input  reg_ptr_t    exec_src1_reg,
    input  reg_ptr_t    exec_dst_reg,
    output int          pass_cnt,
    output int          fail_cnt,
    output logic        report_done
);
    logic [11:0] held_exp [0:11];   // row of the line the DUT sampled last edge
    logic [11:0] held_id;
    logic        held_vld;
    logic [11:0] cur_id;
    logic        cur_seen;
    int          test_errs;
    int          test_cycles;

    task automatic check_field(input string name, input logic [11:0] exp_val,
                               input logic [11:0] act_val);
        if (act_val !== exp_val) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
            test_errs++;
        end
    endtask

    task automatic close_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("test %0d ok, %0d cycles", cur_id, test_cycles);
        end else begin
            fail_cnt++;
            $display("test %0d bad, %0d mismatches in %0d cycles", cur_id, test_errs,
                     test_cycles);
        end
        test_errs   = 0;
        test_cycles = 0;
    endtask

    initial begin
        pass_cnt    = 0;
        fail_cnt    = 0;
        report_done = 1'b0;
        held_vld    = 1'b0;
        cur_seen    = 1'b0;
        test_errs   = 0;
        test_cycles = 0;
    end

    always @(posedge clk) begin
        if (held_vld) begin
            if (cur_seen && held_id != cur_id) begin
                close_test();       // new test id starts
            end
            cur_id   = held_id;
            cur_seen = 1'b1;
            test_cycles++;
            check_field("exec_ctrl", held_exp[0], {8'h0, exec_ctrl});
            check_field("exec_addr", held_exp[1], exec_addr);
            check_field("exec_imm_val", held_exp[2], {4'h0, exec_imm_val});
            check_field("exec_imm_val_vld", held_exp[3], {11'h0, exec_imm_val_vld});
            check_field("decode2ifetch_en", held_exp[4], {11'h0, decode2ifetch_en});
            check_field("decode2exec_en", held_exp[5], {11'h0, decode2exec_en});
            check_field("cr", held_exp[6], {4'h0, cr});
            check_field("exec_src0_reg_rd_en", held_exp[7], {11'h0, exec_src0_reg_rd_en});
            check_field("exec_src1_reg_rd_en", held_exp[8], {11'h0, exec_src1_reg_rd_en});
            check_field("exec_src0_reg", held_exp[9], {10'h0, exec_src0_reg});
            check_field("exec_src1_reg", held_exp[10], {10'h0, exec_src1_reg});
            check_field("exec_dst_reg", held_exp[11], {10'h0, exec_dst_reg});
        end
        if (all_sent && !report_done) begin
            if (cur_seen) begin
                close_test();       // last test
            end
            report_done <= 1'b1;
        end
        held_vld <= case_vld;
        held_id  <= test_id;
        held_exp <= exp_row;
    end

endmodule

//--- hw/inst_decoder.sv
//********************************************************************
// inst_decoder
// instruction decode stage, byte decoder, CR/branch and exec regs
//********************************************************************
module inst_decoder
    import idec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_,
    input  logic      idecode_en,
    input  inst_t     inst_i,
    input  ctrl_reg_t sr,
    input  ctrl_reg_t cr_update,
    input  logic      cr_update_en,
    output exec_op_t  exec_ctrl,
    output reg_ptr_t  exec_src0_reg,
    output logic      exec_src0_reg_rd_en,
    output reg_ptr_t  exec_src1_reg,
    output logic      exec_src1_reg_rd_en,
    output reg_ptr_t  exec_dst_reg,
    output addr_t     exec_addr,
    output imm_t      exec_imm_val,
    output logic      exec_imm_val_vld,
    output logic      decode2ifetch_en,
    output logic      decode2exec_en,
    output ctrl_reg_t cr
);
    cr_op_t cr_op;
    logic   halt_req;
    logic   ignore_byte;    // RET window or halted
    logic   branch_ok;

    decode_bus_if dec_bus ();

    inst_byte_decode u_byte_decode (
        .clk         (clk),
        .reset_      (reset_),
        .idecode_en  (idecode_en),
        .inst        (inst_i),
        .ignore_byte (ignore_byte),
        .cr_op       (cr_op),
        .halt_req    (halt_req),
        .bus         (dec_bus.decoder)
    );

    branch_ctrl u_branch_ctrl (
        .clk          (clk),
        .reset_       (reset_),
        .cr_op        (cr_op),
        .cr_update    (cr_update),
        .cr_update_en (cr_update_en),
        .sr           (sr),
        .cr           (cr),
        .branch_ok    (branch_ok)
    );

    exec_stage_reg u_exec_stage (
        .clk                 (clk),
        .reset_              (reset_),
        .idecode_en          (idecode_en),
        .branch_ok           (branch_ok),
        .halt_req            (halt_req),
        .bus                 (dec_bus.stage),
        .exec_ctrl           (exec_ctrl),
        .exec_src0_reg       (exec_src0_reg),
        .exec_src1_reg       (exec_src1_reg),
        .exec_dst_reg        (exec_dst_reg),
        .exec_src0_reg_rd_en (exec_src0_reg_rd_en),
        .exec_src1_reg_rd_en (exec_src1_reg_rd_en),
        .exec_addr           (exec_addr),
        .exec_imm_val        (exec_imm_val),
        .exec_imm_val_vld    (exec_imm_val_vld),
        .decode2ifetch_en    (decode2ifetch_en),
        .decode2exec_en      (decode2exec_en),
        .ignore_byte         (ignore_byte)
    );

endmodule

//--- hw/exec_stage_reg.sv
//********************************************************************
// exec_stage_reg
// registered execute controls, halt state and the RET restore window
//********************************************************************
module exec_stage_reg
    import idec_pkg::*;
(
    input  logic     clk,
    input  logic     reset_,
    input  logic     idecode_en,
    input  logic     branch_ok,
    input  logic     halt_req,
    decode_bus_if.stage bus,
    output exec_op_t exec_ctrl,
    output reg_ptr_t exec_src0_reg,
    output reg_ptr_t exec_src1_reg,
    output reg_ptr_t exec_dst_reg,
    output logic     exec_src0_reg_rd_en,
    output logic     exec_src1_reg_rd_en,
    output addr_t    exec_addr,
    output imm_t     exec_imm_val,
    output logic     exec_imm_val_vld,
    output logic     decode2ifetch_en,
    output logic     decode2exec_en,
    output logic     ignore_byte
);
    exec_op_t   op_gated;
    logic       exec_en;
    logic       halted;     // sticky until reset
    logic [3:0] ret_sh;     // one bit per cycle after RET
    logic       ret_start;

    // untaken jmp/call becomes a nop
    assign op_gated = ((bus.op == CPU_JMP || bus.op == CPU_CALL) && !branch_ok) ?
                      EXEC_NOP : bus.op;
    assign ret_start = bus.first_byte && (bus.op == CPU_RET);

    assign decode2ifetch_en = ~halted & ~(ret_sh[0] | ret_sh[1]);   // 2 cycle stall
    assign decode2exec_en   = exec_en & ~halted;
    assign ignore_byte      = halted | (|ret_sh);                   // 4 bytes dropped

    always_ff @(posedge clk) begin
        if (!reset_) begin
            exec_ctrl           <= EXEC_NOP;
            exec_src0_reg       <= '0;
            exec_src1_reg       <= '0;
            exec_dst_reg        <= '0;
            exec_src0_reg_rd_en <= 1'b0;
            exec_src1_reg_rd_en <= 1'b0;
            exec_addr           <= '0;
            exec_imm_val        <= '0;
            exec_imm_val_vld    <= 1'b0;
            exec_en             <= 1'b0;
            halted              <= 1'b0;
            ret_sh              <= '0;
        end else begin
            if (idecode_en) begin
                exec_ctrl           <= op_gated;
                exec_src0_reg_rd_en <= bus.src0_rd;
                exec_src1_reg_rd_en <= bus.src1_rd;
                exec_imm_val_vld    <= bus.imm_vld;
            end else begin
                exec_src0_reg_rd_en <= 1'b0;        // idle, fields hold
                exec_src1_reg_rd_en <= 1'b0;
            end
            if (bus.first_byte) begin
                exec_src0_reg <= bus.src0;
                exec_src1_reg <= bus.src1;
                exec_dst_reg  <= bus.dst;
            end
            if (bus.addr_vld) begin
                exec_addr <= bus.addr;
            end
            if (bus.imm_vld) begin
                exec_imm_val <= bus.imm;
            end
            exec_en <= bus.first_byte;
            halted  <= halted | halt_req;
            ret_sh  <= {ret_sh[2:0], ret_start};
        end
    end

endmodule

//--- hw/branch_ctrl.sv
//********************************************************************
// branch_ctrl
// control register with external write port, and the branch
// condition taken from CR and SR
//********************************************************************
module branch_ctrl
    import idec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_,
    input  cr_op_t    cr_op,
    input  ctrl_reg_t cr_update,
    input  logic      cr_update_en,
    input  ctrl_reg_t sr,
    output ctrl_reg_t cr,
    output logic      branch_ok
);
    ctrl_reg_t cr_next;

    // external write first, instruction bit change on top
    always_comb begin
        cr_next = cr_update_en ? cr_update : cr;
        case (cr_op)
            CR_SET_BCZ:  cr_next[CR_BCZ_BIT] = 1'b1;
            CR_SET_BCNZ: cr_next[CR_BCNZ_BIT] = 1'b1;
            CR_CLR_BC: begin
                cr_next[CR_BCZ_BIT]  = 1'b0;
                cr_next[CR_BCNZ_BIT] = 1'b0;
            end
            CR_SET_ADR:  cr_next[CR_ADR_BIT] = 1'b1;
            CR_RST_ADR:  cr_next[CR_ADR_BIT] = 1'b0;
            default: ;                      // no change
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            cr <= CR_RESET;
        end else begin
            cr <= cr_next;
        end
    end

    // {bcnz, bcz} selects the status flag
    always_comb begin
        case ({cr[CR_BCNZ_BIT], cr[CR_BCZ_BIT]})
            2'b11:   branch_ok = sr[SR_OVF_BIT];   // branch on overflow
            2'b01:   branch_ok = sr[SR_Z_BIT];
            2'b10:   branch_ok = sr[SR_NZ_BIT];
            default: branch_ok = 1'b1;             // unconditional
        endcase
    end

endmodule

//--- hw/inst_byte_decode.sv
//********************************************************************
// inst_byte_decode
// splits opcode and operand bytes into execute fields, tracks
// whether the next byte is an immediate or a low address byte
//********************************************************************
module inst_byte_decode
    import idec_pkg::*;
(
    input  logic   clk,
    input  logic   reset_,
    input  logic   idecode_en,
    input  inst_t  inst,
    input  logic   ignore_byte,
    output cr_op_t cr_op,
    output logic   halt_req,
    decode_bus_if.decoder bus
);
    logic  imm_mode;        // next byte is operand
    logic  imm_mode_next;
    logic  accept;
    inst_t prev_inst;       // opcode byte of a two-byte instruction

    function automatic exec_op_t alu_op(input logic [2:0] base);
        case (base)
            BASE_ADD: alu_op = ALU_ADD;
            BASE_SUB: alu_op = ALU_SUB;
            BASE_AND: alu_op = ALU_AND;
            BASE_OR:  alu_op = ALU_OR;
            default:  alu_op = ALU_XOR;
        endcase
    endfunction

    assign accept = idecode_en & ~ignore_byte;

    always_comb begin
        bus.op         = EXEC_NOP;
        bus.src0       = inst[3:2];
        bus.src1       = inst[1:0];
        bus.dst        = inst[1:0];
        bus.src0_rd    = 1'b0;
        bus.src1_rd    = 1'b0;
        bus.addr       = {1'b0, prev_inst[2:0], inst};
        bus.imm        = inst;
        bus.imm_vld    = 1'b0;
        bus.addr_vld   = 1'b0;
        bus.first_byte = accept & ~imm_mode;
        cr_op          = CR_NONE;
        halt_req       = 1'b0;
        imm_mode_next  = imm_mode;      // holds across idle cycles

        if (accept && imm_mode) begin
            imm_mode_next = 1'b0;
            case (prev_inst[7:5])
                BASE_ADD, BASE_SUB, BASE_AND, BASE_OR, BASE_XOR: bus.imm_vld = 1'b1;
                default: bus.addr_vld = 1'b1;       // ld, st, jmp, call
            endcase
        end else if (accept) begin
            case (inst[7:5])
                BASE_CTRL: begin
                    case (inst[4:3])
                        SUB_MISC: begin
                            case (inst[2:0])
                                NOP:          bus.op = EXEC_NOP;
                                RET:          bus.op = CPU_RET;
                                HALT:         halt_req = 1'b1;
                                SET_BCZ:      cr_op = CR_SET_BCZ;
                                SET_BCNZ:     cr_op = CR_SET_BCNZ;
                                CLR_BC:       cr_op = CR_CLR_BC;
                                SET_ADR_MODE: cr_op = CR_SET_ADR;
                                RST_ADR_MODE: cr_op = CR_RST_ADR;
                                default:      bus.op = EXEC_NOP;
                            endcase
                        end
                        SUB_USR: bus.op = EXEC_NOP;     // not implemented
                        SUB_JMP: begin
                            bus.op        = CPU_JMP;
                            imm_mode_next = 1'b1;
                        end
                        SUB_CALL: begin
                            bus.op        = CPU_CALL;
                            imm_mode_next = 1'b1;
                        end
                        default: bus.op = EXEC_NOP;
                    endcase
                end
                BASE_ADD, BASE_SUB, BASE_AND, BASE_OR, BASE_XOR: begin
                    bus.op        = alu_op(inst[7:5]);
                    bus.src0_rd   = 1'b1;
                    bus.src1_rd   = ~inst[ALU_IMM_BIT];
                    imm_mode_next = inst[ALU_IMM_BIT];
                end
                BASE_LD: begin
                    bus.op        = MEM_RD;
                    bus.dst       = inst[4:3];
                    imm_mode_next = 1'b1;
                end
                BASE_ST: begin
                    bus.op        = MEM_WR;
                    bus.src0      = inst[4:3];
                    bus.src0_rd   = 1'b1;
                    imm_mode_next = 1'b1;
                end
                default: bus.op = EXEC_NOP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_) begin
            imm_mode <= 1'b0;
        end else begin
            imm_mode <= imm_mode_next;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.first_byte) begin
            prev_inst <= inst;
        end
    end

endmodule

//--- hw/decode_bus_if.sv
//********************************************************************
// decode_bus_if
// decoded byte fields, byte decoder to execute register stage
//********************************************************************
interface decode_bus_if
    import idec_pkg::*;
();
    exec_op_t op;
    reg_ptr_t src0;
    reg_ptr_t src1;
    reg_ptr_t dst;
    logic     src0_rd;
    logic     src1_rd;
    addr_t    addr;
    imm_t     imm;
    logic     imm_vld;      // alu second byte
    logic     addr_vld;     // ld/st/jmp/call second byte
    logic     first_byte;   // accepted opcode byte

    modport decoder (output op, src0, src1, dst, src0_rd, src1_rd,
                     addr, imm, imm_vld, addr_vld, first_byte);
    modport stage   (input  op, src0, src1, dst, src0_rd, src1_rd,
                     addr, imm, imm_vld, addr_vld, first_byte);
endinterface

//--- hw/idec_pkg.sv
//********************************************************************
// idec_pkg
// opcode fields, CR/SR bit map, widths and enums for the decode stage
//********************************************************************
package idec_pkg;

    typedef logic [7:0]  inst_t;        // one instruction byte
    typedef logic [1:0]  reg_ptr_t;     // register file index
    typedef logic [11:0] addr_t;        // data / program address
    typedef logic [7:0]  imm_t;
    typedef logic [7:0]  ctrl_reg_t;    // CR, also SR

    typedef enum logic [3:0] {
        EXEC_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        MEM_RD,
        MEM_WR,
        CPU_JMP,
        CPU_CALL,
        CPU_RET
    } exec_op_t;

    typedef enum logic [2:0] {
        CR_NONE,
        CR_SET_BCZ,
        CR_SET_BCNZ,
        CR_CLR_BC,
        CR_SET_ADR,
        CR_RST_ADR
    } cr_op_t;

    // base op, inst[7:5]
    localparam logic [2:0] BASE_CTRL = 3'd0;
    localparam logic [2:0] BASE_ADD  = 3'd1;
    localparam logic [2:0] BASE_SUB  = 3'd2;
    localparam logic [2:0] BASE_AND  = 3'd3;
    localparam logic [2:0] BASE_OR   = 3'd4;
    localparam logic [2:0] BASE_XOR  = 3'd5;
    localparam logic [2:0] BASE_LD   = 3'd6;
    localparam logic [2:0] BASE_ST   = 3'd7;

    // control group, inst[4:3]
    localparam logic [1:0] SUB_MISC = 2'd0;
    localparam logic [1:0] SUB_USR  = 2'd1;
    localparam logic [1:0] SUB_JMP  = 2'd2;
    localparam logic [1:0] SUB_CALL = 2'd3;

    // misc codes, inst[2:0]
    localparam logic [2:0] NOP          = 3'd0;
    localparam logic [2:0] RET          = 3'd1;
    localparam logic [2:0] HALT         = 3'd2;
    localparam logic [2:0] SET_BCZ      = 3'd3;
    localparam logic [2:0] SET_BCNZ     = 3'd4;
    localparam logic [2:0] CLR_BC       = 3'd5;
    localparam logic [2:0] SET_ADR_MODE = 3'd6;
    localparam logic [2:0] RST_ADR_MODE = 3'd7;

    localparam int ALU_IMM_BIT = 4;

    localparam int CR_BCZ_BIT  = 0;
    localparam int CR_BCNZ_BIT = 1;
    localparam int CR_SP_LSB   = 2;     // sp msb 10..8 in cr[4:2]
    localparam int CR_ADR_BIT  = 5;

    localparam ctrl_reg_t CR_RESET = ctrl_reg_t'(8'h07 << CR_SP_LSB);  // 8'h1c

    localparam int SR_OVF_BIT = 0;
    localparam int SR_NZ_BIT  = 2;
    localparam int SR_Z_BIT   = 3;

endpackage
